//--- Bender.yml
package:
  name: pd_block_loader

sources:
  - include_dirs:
      - src
    files:
      - src/pd_pkg.sv
      - src/pd_skid_buffer.sv
      - src/pd_byte_loader.sv
      - src/pd_block_storage.sv
      - src/pd_word_streamer.sv
      - src/pd_block_top.sv
      - target: test
        files:
          - tb/tb_pd_block_top.sv

//--- src/pd_block_storage.sv
/*
 * Block storage
 * 112-byte store with a per-byte written mask, locks once every byte
 * has been written, serves little-endian words until released
 */

`timescale 1ns/1ps
`include "pd_macros.svh"

module pd_block_storage (
	input  logic               tb_clk,
	input  logic               arst_n,
	input  logic               wr_en,
	input  pd_pkg::byte_sel_t  wr_sel,
	input  pd_pkg::byte_t      wr_data,
	input  pd_pkg::word_idx_t  rd_idx,
	output pd_pkg::hash_word_t rd_word,
	output logic               locked,
	input  logic               blk_release
);

	pd_pkg::byte_t mem [`PD_BLOCK_BYTES];
	logic [`PD_BLOCK_BYTES-1:0] written;
	logic [`PD_BLOCK_BYTES-1:0] written_next;
	pd_pkg::byte_sel_t rd_base;

	// Mask including the write of this cycle
	always_comb
	begin
		written_next = written;
		if (wr_en)
			written_next[wr_sel] = 1'b1;
	end

	// Byte array where later writes to a select win
	always_ff @(posedge tb_clk)
	begin
		if (wr_en)
			mem[wr_sel] <= wr_data;
	end

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			written <= '0;
			locked  <= 1'b0;
		end
		else if (blk_release)
		begin
			// Open for the next block once streamed
			written <= '0;
			locked  <= 1'b0;
		end
		else
		begin
			written <= written_next;
			// Lock on the edge of the completing write
			if (&written_next)
				locked <= 1'b1;
		end
	end

	// First byte of the word
	assign rd_base = {rd_idx, 2'b00};

	// Lowest address in bits 7:0
	always_comb
	begin
		for (int b = 0; b < `PD_WORD_BYTES; b++)
			rd_word[8*b +: 8] = mem[rd_base + b];
	end

	// Streamer only frees a block it was handed
	a_release_locked: assert property (@(posedge tb_clk) disable iff (!arst_n)
		blk_release |-> locked);

	// Loader held off while the block is out for streaming
	a_no_write_locked: assert property (@(posedge tb_clk) disable iff (!arst_n)
		locked |-> !wr_en);

endmodule

//--- src/pd_block_top.sv
/*
 * Proof-of-work block loader top
 * Host byte beats in, field-tagged little-endian words out
 */

`timescale 1ns/1ps

module pd_block_top (
	input  logic               tb_clk,
	input  logic               arst_n,
	input  logic               load_valid,
	output logic               load_ready,
	input  pd_pkg::byte_sel_t  load_sel,
	input  pd_pkg::byte_t      load_data,
	output logic               word_valid,
	input  logic               word_ready,
	output pd_pkg::hash_word_t word_data,
	output pd_pkg::field_t     word_field,
	output logic               word_last,
	output pd_pkg::bad_count_t bad_sel_count
);

	pd_pkg::load_beat_t in_beat;
	pd_pkg::load_beat_t beat;
	logic beat_valid;
	logic beat_ready;
	logic wr_en;
	pd_pkg::byte_sel_t wr_sel;
	pd_pkg::byte_t wr_data;
	logic locked;
	logic blk_release;
	pd_pkg::word_idx_t rd_idx;
	pd_pkg::hash_word_t rd_word;
	logic str_valid;
	logic str_ready;
	pd_pkg::word_beat_t str_beat;
	pd_pkg::word_beat_t out_beat;

	// Pack host beat
	assign in_beat.sel  = load_sel;
	assign in_beat.data = load_data;

	pd_skid_buffer #(
		.payload_t(pd_pkg::load_beat_t)
	) u_in_buf (
		.tb_clk    (tb_clk),
		.arst_n    (arst_n),
		.in_valid  (load_valid),
		.in_ready  (load_ready),
		.in_data   (in_beat),
		.out_valid (beat_valid),
		.out_ready (beat_ready),
		.out_data  (beat)
	);

	pd_byte_loader u_loader (
		.tb_clk        (tb_clk),
		.arst_n        (arst_n),
		.beat_valid    (beat_valid),
		.beat          (beat),
		.beat_ready    (beat_ready),
		.locked        (locked),
		.wr_en         (wr_en),
		.wr_sel        (wr_sel),
		.wr_data       (wr_data),
		.bad_sel_count (bad_sel_count)
	);

	pd_block_storage u_storage (
		.tb_clk      (tb_clk),
		.arst_n      (arst_n),
		.wr_en       (wr_en),
		.wr_sel      (wr_sel),
		.wr_data     (wr_data),
		.rd_idx      (rd_idx),
		.rd_word     (rd_word),
		.locked      (locked),
		.blk_release (blk_release)
	);

	pd_word_streamer u_streamer (
		.tb_clk      (tb_clk),
		.arst_n      (arst_n),
		.locked      (locked),
		.rd_idx      (rd_idx),
		.rd_word     (rd_word),
		.blk_release (blk_release),
		.out_valid   (str_valid),
		.out_ready   (str_ready),
		.out_data    (str_beat)
	);

	pd_skid_buffer #(
		.payload_t(pd_pkg::word_beat_t)
	) u_out_buf (
		.tb_clk    (tb_clk),
		.arst_n    (arst_n),
		.in_valid  (str_valid),
		.in_ready  (str_ready),
		.in_data   (str_beat),
		.out_valid (word_valid),
		.out_ready (word_ready),
		.out_data  (out_beat)
	);

	// Unpack toward the hash core
	assign word_data  = out_beat.word;
	assign word_field = out_beat.field;
	assign word_last  = out_beat.last;

endmodule

//--- src/pd_byte_loader.sv
/*
 * Block byte loader
 * Takes host byte beats, writes in-range selects into block storage,
 * drops and counts selects past the end of the block
 */

`timescale 1ns/1ps
`include "pd_macros.svh"

module pd_byte_loader (
	input  logic               tb_clk,
	input  logic               arst_n,
	input  logic               beat_valid,
	input  pd_pkg::load_beat_t beat,
	output logic               beat_ready,
	input  logic               locked,
	output logic               wr_en,
	output pd_pkg::byte_sel_t  wr_sel,
	output pd_pkg::byte_t      wr_data,
	output pd_pkg::bad_count_t bad_sel_count
);

	logic accept;
	logic in_range;

	// Stall the host while a full block waits for the streamer
	assign beat_ready = !locked;
	assign accept     = beat_valid && beat_ready;
	assign in_range   = (beat.sel < `PD_BLOCK_BYTES);

	// Write goes out in the accept cycle
	assign wr_en   = accept && in_range;
	assign wr_sel  = beat.sel;
	assign wr_data = beat.data;

	// Bad selects consumed here and never written
	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
			bad_sel_count <= '0;
		else if (accept && !in_range && (bad_sel_count != '1))
			bad_sel_count <= bad_sel_count + 1'b1;
	end

	// Stalled beat held steady by the input buffer
	a_beat_stable: assert property (@(posedge tb_clk) disable iff (!arst_n)
		beat_valid && !beat_ready |=> beat_valid && $stable(beat));

endmodule

//--- src/pd_macros.svh
/*
 * Block layout sizes for the proof-of-work loader
 * Field sizes in bytes, block totals derived from them
 */

`ifndef PD_MACROS_SVH
`define PD_MACROS_SVH

// Field sizes
`define PD_CHUNK1_BYTES 64
`define PD_CHUNK2_BYTES 16
`define PD_DIFF_BYTES 32

// Output word width in bytes
`define PD_WORD_BYTES 4

// Totals, 112 bytes and 28 words
`define PD_BLOCK_BYTES (`PD_CHUNK1_BYTES + `PD_CHUNK2_BYTES + `PD_DIFF_BYTES)
`define PD_BLOCK_WORDS (`PD_BLOCK_BYTES / `PD_WORD_BYTES)

`endif

//--- src/pd_pkg.sv
/*
 * Proof-of-work block loader types
 * Byte, select, word, field tag and beat types shared by the loader path
 */

package pd_pkg;

	// One block byte from the host
	typedef logic [7:0] byte_t;

	// Byte select, covers 0 to 127 so bad selects can be seen
	typedef logic [6:0] byte_sel_t;

	// Word index into the locked block, 0 to 27
	typedef logic [4:0] word_idx_t;

	// Little-endian word toward the hash core
	typedef logic [31:0] hash_word_t;

	// Which block field a word belongs to
	typedef enum logic [1:0]
	{
		FIELD_CHUNK1 = 2'd0,
		FIELD_CHUNK2 = 2'd1,
		FIELD_DIFF   = 2'd2
	} field_t;

	// Host byte beat
	typedef struct packed
	{
		byte_sel_t sel;
		byte_t     data;
	} load_beat_t;

	// Tagged output word
	typedef struct packed
	{
		hash_word_t word;
		field_t     field;
		logic       last;
	} word_beat_t;

	// Dropped-beat count, saturates at all ones
	typedef logic [15:0] bad_count_t;

endpackage

//--- src/pd_skid_buffer.sv
/*
 * Two-entry valid/ready buffer
 * Registered FIFO with a generic payload type, cuts the ready path
 */

`timescale 1ns/1ps

module pd_skid_buffer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     tb_clk,
	input  logic     arst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// Entry storage, payload only
	payload_t mem [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count;
	logic push;
	logic pop;

	// Ready and valid from the occupancy register only
	assign in_ready  = (count != 2'd2);
	assign out_valid = (count != 2'd0);
	assign out_data  = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end
		else
		begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			// Occupancy moves only on one-sided transfers
			case ({push, pop})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	// Write into the free slot
	always_ff @(posedge tb_clk)
	begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	// Stalled head entry is neither dropped nor overwritten by a push
	a_hold_stable: assert property (@(posedge tb_clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- src/pd_word_streamer.sv
/*
 * Locked block word streamer
 * Reads the locked block as 28 field-tagged words toward the hash core,
 * then releases the storage for the next block
 */

`timescale 1ns/1ps
`include "pd_macros.svh"

module pd_word_streamer (
	input  logic               tb_clk,
	input  logic               arst_n,
	input  logic               locked,
	output pd_pkg::word_idx_t  rd_idx,
	input  pd_pkg::hash_word_t rd_word,
	output logic               blk_release,
	output logic               out_valid,
	input  logic               out_ready,
	output pd_pkg::word_beat_t out_data
);

	// Field boundaries in words
	localparam int CHUNK2_FIRST = `PD_CHUNK1_BYTES / `PD_WORD_BYTES;
	localparam int DIFF_FIRST   = (`PD_CHUNK1_BYTES + `PD_CHUNK2_BYTES) / `PD_WORD_BYTES;
	localparam int LAST_WORD    = `PD_BLOCK_WORDS - 1;

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_RUN,
		ST_DRAIN,
		ST_REL,
		ST_WAIT
	} state_t;

	state_t state;
	pd_pkg::field_t field;
	logic load_word;

	// Tag for the word at rd_idx
	always_comb
	begin
		if (rd_idx < CHUNK2_FIRST)
			field = pd_pkg::FIELD_CHUNK1;
		else if (rd_idx < DIFF_FIRST)
			field = pd_pkg::FIELD_CHUNK2;
		else
			field = pd_pkg::FIELD_DIFF;
	end

	// Output register empty or emptying this cycle
	assign load_word   = (state == ST_RUN) && (!out_valid || out_ready);
	assign blk_release = (state == ST_REL);

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= ST_IDLE;
			rd_idx    <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (locked)
					begin
						rd_idx <= '0;
						state  <= ST_RUN;
					end
				end
				ST_RUN:
				begin
					if (load_word)
					begin
						out_valid <= 1'b1;
						if (rd_idx == LAST_WORD)
							state <= ST_DRAIN;
						else
							rd_idx <= rd_idx + 1'b1;
					end
				end
				ST_DRAIN:
				begin
					// Last word still waiting in the register
					if (out_ready)
					begin
						out_valid <= 1'b0;
						state     <= ST_REL;
					end
				end
				ST_REL:
					state <= ST_WAIT;
				ST_WAIT:
				begin
					if (!locked)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Word register held while stalled
	always_ff @(posedge tb_clk)
	begin
		if (load_word)
		begin
			out_data.word  <= rd_word;
			out_data.field <= field;
			out_data.last  <= (rd_idx == LAST_WORD);
		end
	end

	// Storage drops the lock on the release edge
	a_release_unlocks: assert property (@(posedge tb_clk) disable iff (!arst_n)
		blk_release |=> !locked);

endmodule

//--- tb/tb_pd_block_top.sv
/*
 * Testbench for the proof-of-work block loader
 * Random byte beats against a block model, checks tagged words and drop count
 */

`timescale 1ns/1ps
`include "pd_macros.svh"

module tb_pd_block_top;

	localparam int CLK_HALF   = 4;
	localparam int CLK_PERIOD = 2 * CLK_HALF;
	localparam int NUM_BLOCKS = 12;
	// Worst stall, cycles per beat or word with gaps and back-pressure
	localparam int STALL      = 8;
	localparam int TIMEOUT_NS =
		NUM_BLOCKS * (`PD_BLOCK_BYTES + `PD_BLOCK_WORDS) * STALL * CLK_PERIOD;

	logic tb_clk;
	logic arst_n;
	logic load_valid;
	logic load_ready;
	pd_pkg::byte_sel_t load_sel;
	pd_pkg::byte_t load_data;
	logic word_valid;
	logic word_ready;
	pd_pkg::hash_word_t word_data;
	pd_pkg::field_t word_field;
	logic word_last;
	pd_pkg::bad_count_t bad_sel_count;

	integer seed = 32'h5235;
	integer bp_seed = 32'h5235 ^ 32'h00ff;

	// Stimulus knobs, percent
	int gap_pct = 0;
	int rep_pct = 0;
	int bad_pct = 0;
	int ready_pct = 100;
	bit ready_low_seen = 1'b0;

	// Block model
	pd_pkg::byte_t model_mem [`PD_BLOCK_BYTES];
	logic [`PD_BLOCK_BYTES-1:0] model_mask = '0;
	pd_pkg::bad_count_t model_bad = '0;
	pd_pkg::hash_word_t exp_words [$];
	pd_pkg::field_t exp_fields [$];
	logic exp_lasts [$];
	int blocks_made = 0;
	int blocks_done = 0;
	int word_count = 0;

	pd_block_top UUT (
		.tb_clk        (tb_clk),
		.arst_n        (arst_n),
		.load_valid    (load_valid),
		.load_ready    (load_ready),
		.load_sel      (load_sel),
		.load_data     (load_data),
		.word_valid    (word_valid),
		.word_ready    (word_ready),
		.word_data     (word_data),
		.word_field    (word_field),
		.word_last     (word_last),
		.bad_sel_count (bad_sel_count)
	);

	always #(CLK_HALF) tb_clk = ~tb_clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic check_word(input pd_pkg::hash_word_t got_word, input pd_pkg::hash_word_t exp_word,
		input pd_pkg::field_t got_field, input pd_pkg::field_t exp_field,
		input logic got_last, input logic exp_last);
		if (got_word !== exp_word || got_field !== exp_field || got_last !== exp_last)
			abort_run($sformatf("FAIL %0t: word %0d got %h/%0d/%b expected %h/%0d/%b",
				$time, word_count, got_word, got_field, got_last, exp_word, exp_field, exp_last));
	endtask

	task automatic check_count(input pd_pkg::bad_count_t got, input pd_pkg::bad_count_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %0t: bad_sel_count %0d expected %0d", $time, got, exp));
	endtask

	// Accepted beat into the model, full block becomes 28 expected words
	task automatic apply_beat(input pd_pkg::byte_sel_t sel, input pd_pkg::byte_t data);
		pd_pkg::field_t fld;
		if (sel >= `PD_BLOCK_BYTES)
			model_bad++;
		else
		begin
			model_mem[sel] = data;
			model_mask[sel] = 1'b1;
		end
		if (&model_mask)
		begin
			for (int w = 0; w < `PD_BLOCK_WORDS; w++)
			begin
				// Byte offset of the word picks its field
				if (w * `PD_WORD_BYTES < `PD_CHUNK1_BYTES)
					fld = pd_pkg::FIELD_CHUNK1;
				else if (w * `PD_WORD_BYTES < `PD_CHUNK1_BYTES + `PD_CHUNK2_BYTES)
					fld = pd_pkg::FIELD_CHUNK2;
				else
					fld = pd_pkg::FIELD_DIFF;
				exp_words.push_back({model_mem[4*w+3], model_mem[4*w+2],
					model_mem[4*w+1], model_mem[4*w]});
				exp_fields.push_back(fld);
				exp_lasts.push_back(w == `PD_BLOCK_WORDS - 1);
			end
			model_mask = '0;
			blocks_made++;
		end
	endtask

	// Called on a falling edge, returns on the falling edge after the handshake
	task automatic drive_beat(input pd_pkg::byte_sel_t sel, input pd_pkg::byte_t data);
		while (rand_below(100) < gap_pct)
		begin
			load_valid = 1'b0;
			@(negedge tb_clk);
		end
		load_valid = 1'b1;
		load_sel = sel;
		load_data = data;
		// load_ready is registered, stable until the next rising edge
		while (!load_ready)
		begin
			ready_low_seen = 1'b1;
			@(negedge tb_clk);
		end
		apply_beat(sel, data);
		@(negedge tb_clk);
	endtask

	// One full block, the last distinct select always comes last
	task automatic send_block(input bit in_order);
		int perm [`PD_BLOCK_BYTES];
		int j;
		int tmp;
		for (int i = 0; i < `PD_BLOCK_BYTES; i++)
			perm[i] = i;
		if (!in_order)
		begin
			for (int i = `PD_BLOCK_BYTES - 1; i > 0; i--)
			begin
				j = rand_below(i + 1);
				tmp = perm[i];
				perm[i] = perm[j];
				perm[j] = tmp;
			end
		end
		for (int i = 0; i < `PD_BLOCK_BYTES; i++)
		begin
			// Rewrite of a byte already sent in this block
			if (i > 0 && rand_below(100) < rep_pct)
				drive_beat(perm[rand_below(i)], pd_pkg::byte_t'($random(seed)));
			if (rand_below(100) < bad_pct)
				drive_beat(`PD_BLOCK_BYTES + rand_below(16), pd_pkg::byte_t'($random(seed)));
			drive_beat(perm[i], pd_pkg::byte_t'($random(seed)));
		end
		load_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_words.size() != 0)
			@(negedge tb_clk);
	endtask

	task automatic run_blocks(input int n, input bit in_order, input bit drain_each);
		for (int b = 0; b < n; b++)
		begin
			send_block(in_order);
			if (drain_each)
			begin
				wait_drained();
				check_count(bad_sel_count, model_bad);
			end
		end
	endtask

	// Word side, ready decided and data checked on the falling edge
	initial
	begin
		forever
		begin
			@(negedge tb_clk);
			word_ready = ($unsigned($random(bp_seed)) % 100) < ready_pct;
			if (word_valid)
			begin
				if (exp_words.size() == 0)
					abort_run("Word offered while no complete block was loaded");
				else if (word_ready)
				begin
					check_word(word_data, exp_words.pop_front(), word_field,
						exp_fields.pop_front(), word_last, exp_lasts[0]);
					if (exp_lasts.pop_front())
						blocks_done++;
					word_count++;
				end
			end
		end
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		abort_run($sformatf("Timeout: run did not finish within %0d ns", TIMEOUT_NS));
	end

	initial
	begin
		tb_clk = 1'b0;
		arst_n = 1'b0;
		load_valid = 1'b0;
		load_sel = '0;
		load_data = '0;
		word_ready = 1'b0;
		repeat (5) @(posedge tb_clk);
		@(negedge tb_clk);
		arst_n = 1'b1;
		@(negedge tb_clk);
		if (!load_ready || word_valid)
			abort_run("Handshake outputs wrong after reset");

		// In-order block, no stalls
		run_blocks(1, 1'b1, 1'b1);
		// Shuffled selects with rewrites
		rep_pct = 30;
		run_blocks(2, 1'b0, 1'b1);
		// Out-of-range selects mixed in
		rep_pct = 10;
		bad_pct = 15;
		run_blocks(2, 1'b0, 1'b1);
		// Word side back-pressure
		bad_pct = 5;
		ready_pct = 40;
		run_blocks(2, 1'b0, 1'b1);

		// Next block offered while the previous one is held
		ready_pct = 30;
		ready_low_seen = 1'b0;
		run_blocks(2, 1'b0, 1'b0);
		if (!ready_low_seen)
			abort_run("load_ready never dropped while a block was held");
		wait_drained();
		check_count(bad_sel_count, model_bad);

		// Back-to-back blocks with host gaps
		gap_pct = 40;
		ready_pct = 70;
		run_blocks(3, 1'b0, 1'b0);
		wait_drained();
		check_count(bad_sel_count, model_bad);

		// Room for any extra word to show up
		repeat (2 * `PD_BLOCK_WORDS) @(negedge tb_clk);
		if (blocks_done != blocks_made || blocks_made != NUM_BLOCKS)
			abort_run($sformatf("Streamed %0d blocks, loaded %0d", blocks_done, blocks_made));
		else
		begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

//--- vlog.f
+incdir+src
src/pd_pkg.sv
src/pd_skid_buffer.sv
src/pd_byte_loader.sv
src/pd_block_storage.sv
src/pd_word_streamer.sv
src/pd_block_top.sv
tb/tb_pd_block_top.sv
